//--- burst_ctrl.sv
module burst_ctrl #(
    parameter dma_pkg::addr_t wr_base_addr = 32'h0200_0000
) (
    input  logic            M_AXI_ACLK,
    input  logic            M_AXI_ARESETN,
    input  dma_pkg::level_t level,
    input  logic            wr_enable,
    input  logic            base_load,
    input  dma_pkg::addr_t  frame_base,
    input  logic            burst_end,
    input  logic            awready,
    output logic            awvalid,
    output dma_pkg::addr_t  awaddr,
    output logic            wr_req,
    output logic            wr_burst_now
);

    import dma_pkg::*;

    logic start;
    logic aw_hs;

    // enough pixels queued for a whole burst
    assign wr_req = (level >= level_t'(burst_len));

    // grant only counts while idle
    assign start = wr_req && wr_enable && !wr_burst_now;
    assign aw_hs = awvalid && awready;

    // busy from grant until the last beat is accepted
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            wr_burst_now <= 1'b0;
        end else if (burst_end) begin
            wr_burst_now <= 1'b0;
        end else if (start) begin
            wr_burst_now <= 1'b1;
        end
    end

    // one address per burst, held through awready stalls
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            awvalid <= 1'b0;
        end else if (aw_hs) begin
            awvalid <= 1'b0;
        end else if (start) begin
            awvalid <= 1'b1;
        end
    end

    // running address
    // reset lands in buffer 0, new frame reloads the slot base
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            awaddr <= wr_base_addr;
        end else if (base_load) begin
            awaddr <= wr_base_addr + frame_base;
        end else if (aw_hs) begin
            awaddr <= awaddr + addr_t'(burst_bytes);
        end
    end

endmodule

//--- dma_frame_writer.sv
module dma_frame_writer #(
    parameter dma_pkg::addr_t wr_base_addr = 32'h0200_0000
) (
    input  logic                             M_AXI_ACLK,
    input  logic                             M_AXI_ARESETN,

    // aw channel
    output dma_pkg::addr_t                   m_axi_awaddr,
    output logic [7:0]                       m_axi_awlen,
    output logic [2:0]                       m_axi_awsize,
    output logic [1:0]                       m_axi_awburst,
    output logic                             m_axi_awvalid,
    input  logic                             m_axi_awready,

    // w channel
    output dma_pkg::beat_t                   m_axi_wdata,
    output logic [dma_pkg::beat_bytes-1:0]   m_axi_wstrb,
    output logic                             m_axi_wlast,
    output logic                             m_axi_wvalid,
    input  logic                             m_axi_wready,

    // b channel, response not checked
    input  logic [1:0]                       m_axi_bresp,
    input  logic                             m_axi_bvalid,
    output logic                             m_axi_bready,

    // video in
    input  logic                             pre_vs,
    input  logic                             pre_de,
    input  logic [dma_pkg::pixel_w-1:0]      pre_data,

    // arbiter side
    output logic                             wr_req,
    input  logic                             wr_enable,
    output logic                             wr_burst_now,
    output logic                             wr_burst_end
);

    import dma_pkg::*;

    logic   vs_rise;
    logic   base_load;
    addr_t  frame_base;
    beat_t  pixel_beat;
    logic   fifo_pop;
    level_t fifo_level;

    // fixed burst attributes
    assign m_axi_awlen   = 8'(burst_len - 1);
    assign m_axi_awsize  = 3'($clog2(beat_bytes));
    // incr
    assign m_axi_awburst = 2'b01;
    assign m_axi_wstrb   = '1;

    // pixel padded with zeros up to a full beat
    assign pixel_beat = {{(data_w - pixel_w){1'b0}}, pre_data};

    // write responses always accepted once out of reset
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            m_axi_bready <= 1'b0;
        end else begin
            m_axi_bready <= 1'b1;
        end
    end

    frame_sync u_frame_sync (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .pre_vs        (pre_vs),
        .vs_rise       (vs_rise),
        .base_load     (base_load),
        .frame_base    (frame_base)
    );

    // fifo head feeds wdata directly
    pixel_fifo #(
        .depth (fifo_depth)
    ) u_pixel_fifo (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .flush         (vs_rise),
        .push          (pre_de),
        .push_data     (pixel_beat),
        .pop           (fifo_pop),
        .head          (m_axi_wdata),
        .level         (fifo_level)
    );

    burst_ctrl #(
        .wr_base_addr (wr_base_addr)
    ) u_burst_ctrl (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .level         (fifo_level),
        .wr_enable     (wr_enable),
        .base_load     (base_load),
        .frame_base    (frame_base),
        .burst_end     (wr_burst_end),
        .awready       (m_axi_awready),
        .awvalid       (m_axi_awvalid),
        .awaddr        (m_axi_awaddr),
        .wr_req        (wr_req),
        .wr_burst_now  (wr_burst_now)
    );

    wdata_beat u_wdata_beat (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .awvalid       (m_axi_awvalid),
        .awready       (m_axi_awready),
        .wready        (m_axi_wready),
        .wvalid        (m_axi_wvalid),
        .wlast         (m_axi_wlast),
        .pop           (fifo_pop),
        .burst_end     (wr_burst_end)
    );

endmodule

//--- dma_pkg.sv
package dma_pkg;

    // axi bus geometry
    localparam int addr_w     = 32;
    localparam int data_w     = 64;
    localparam int beat_bytes = data_w / 8;

    // video input pixel, rgb888
    localparam int pixel_w = 24;

    // one fixed-length incrementing burst
    localparam int burst_len   = 16;
    localparam int burst_bytes = burst_len * beat_bytes;

    // image size, small by default for simulation
    localparam int image_w = 16;
    localparam int image_h = 4;

    // one pixel per beat, so a buffer holds w*h beats
    localparam int frame_bytes = image_w * image_h * beat_bytes;

    // triple buffering
    localparam int buff_num = 3;

    // pixel fifo, a few bursts deep
    localparam int fifo_depth = 64;

    typedef logic [data_w-1:0] beat_t;
    typedef logic [addr_w-1:0] addr_t;

    // buffer slot index, 0 .. buff_num-1
    typedef logic [1:0] slot_t;

    // counts 0 .. burst_len
    typedef logic [$clog2(burst_len+1)-1:0] beat_cnt_t;

    // occupancy 0 .. fifo_depth, inclusive
    typedef logic [$clog2(fifo_depth+1)-1:0] level_t;

endpackage

//--- frame_sync.sv
module frame_sync (
    input  logic           M_AXI_ACLK,
    input  logic           M_AXI_ARESETN,
    input  logic           pre_vs,
    output logic           vs_rise,
    output logic           base_load,
    output dma_pkg::addr_t frame_base
);

    import dma_pkg::*;

    // vsync one cycle late, for edge detection
    logic  vs_d;
    logic  vs_fall;
    slot_t slot;
    slot_t slot_next;

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            vs_d <= 1'b0;
        end else begin
            vs_d <= pre_vs;
        end
    end

    // frame start, used to flush the pixel fifo
    assign vs_rise = pre_vs && !vs_d;
    // frame end, moves on to the next buffer
    assign vs_fall = !pre_vs && vs_d;

    // wrap after the last buffer
    always_comb begin
        if (slot == slot_t'(buff_num - 1)) begin
            slot_next = '0;
        end else begin
            slot_next = slot + 1'b1;
        end
    end

    // slot and its base offset move together
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            slot       <= '0;
            frame_base <= '0;
        end else if (vs_fall) begin
            slot       <= slot_next;
            frame_base <= addr_t'(slot_next) * addr_t'(frame_bytes);
        end
    end

    // load strobe trails the edge by one cycle
    // so frame_base has already settled
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            base_load <= 1'b0;
        end else begin
            base_load <= vs_fall;
        end
    end

endmodule

//--- pixel_fifo.sv
module pixel_fifo #(
    parameter int depth = dma_pkg::fifo_depth
) (
    input  logic            M_AXI_ACLK,
    input  logic            M_AXI_ARESETN,
    input  logic            flush,
    input  logic            push,
    input  dma_pkg::beat_t  push_data,
    input  logic            pop,
    output dma_pkg::beat_t  head,
    output dma_pkg::level_t level
);

    import dma_pkg::*;

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    // storage
    beat_t            mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic             full;
    logic             empty;
    logic             push_ok;
    logic             pop_ok;

    assign full    = (level == level_t'(depth));
    assign empty   = (level == '0);
    // a push into a full fifo is lost
    // flush wins over both sides
    assign push_ok = push && !full && !flush;
    assign pop_ok  = pop && !empty && !flush;

    // first word fall through
    // head is valid while not empty
    assign head = empty ? '0 : mem[rd_ptr];

    always_ff @(posedge M_AXI_ACLK) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap explicitly since depth need not be a power of two
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // count only moves when one side acts alone
            if (push_ok && !pop_ok) begin
                level <= level + 1'b1;
            end else if (pop_ok && !push_ok) begin
                level <= level - 1'b1;
            end
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dma_frame_writer -f src.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "Test passed" sim.log; then
    exit 0
fi
exit 1

//--- src.f
dma_pkg.sv
frame_sync.sv
pixel_fifo.sv
burst_ctrl.sv
wdata_beat.sv
dma_frame_writer.sv
tb_axi_slave.sv
tb_dma_frame_writer.sv

//--- tb_axi_slave.sv
module tb_axi_slave #(
    parameter dma_pkg::addr_t wr_base_addr = 32'h0200_0000
) (
    input  logic                           M_AXI_ACLK,
    input  logic                           M_AXI_ARESETN,
    input  logic                           grant_en,
    input  logic                           pre_vs,
    input  logic                           pre_de,
    input  logic [dma_pkg::pixel_w-1:0]    pre_data,
    input  dma_pkg::addr_t                 m_axi_awaddr,
    input  logic [7:0]                     m_axi_awlen,
    input  logic [2:0]                     m_axi_awsize,
    input  logic [1:0]                     m_axi_awburst,
    input  logic                           m_axi_awvalid,
    output logic                           m_axi_awready = 1'b0,
    input  dma_pkg::beat_t                 m_axi_wdata,
    input  logic [dma_pkg::beat_bytes-1:0] m_axi_wstrb,
    input  logic                           m_axi_wlast,
    input  logic                           m_axi_wvalid,
    output logic                           m_axi_wready = 1'b0,
    input  logic                           m_axi_bready,
    input  logic                           wr_req,
    output logic                           wr_enable = 1'b0,
    input  logic                           wr_burst_now,
    input  logic                           wr_burst_end,
    output logic [31:0]                    rnd,
    output int                             aw_cnt = 0,
    output int                             end_cnt = 0,
    output int                             mismatch_cnt = 0,
    output int                             fault_cnt = 0
);

    import dma_pkg::*;

    logic [31:0] rng = 32'd93643;
    // pixels pushed and not yet seen on the w channel
    beat_t       exp_q[$];
    int          vs_falls = 0;
    int          burst_idx = 0;
    int          beat_idx = 0;
    int          aw_open = 0;
    logic        rst_prev = 1'b0;
    logic        vs_prev = 1'b0;
    logic        start_prev = 1'b0;
    // expected level of wr_burst_now
    logic        busy_exp = 1'b0;
    logic        aw_prev = 1'b0;
    logic        wv_prev = 1'b0;
    logic        aw_hs_prev = 1'b0;
    logic        aw_stall = 1'b0;
    logic        w_stall = 1'b0;
    addr_t       awaddr_prev = '0;
    beat_t       wdata_prev = '0;
    logic        wlast_prev = 1'b0;

    assign rnd = rng;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // axi size code is log2 of the bytes per beat
    function automatic logic [2:0] size_code(input int bytes);
        int s;
        s = 0;
        while ((1 << s) < bytes) begin
            s++;
        end
        return 3'(s);
    endfunction

    task automatic show_mismatch(input string sig, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
        $display("mismatch at %0t: %s expected %0h got %0h", $time, sig, exp_v, act_v);
        mismatch_cnt++;
    endtask

    task automatic count_fault(input string what);
        $display("error at %0t: %s", $time, what);
        fault_cnt++;
    endtask

    // all samples are the values held during the cycle that just ended
    always @(posedge M_AXI_ACLK) begin
        logic [31:0] nxt;
        logic        live;
        logic        last_beat;
        logic        req_exp;
        logic        burst_done;
        addr_t       exp_addr;
        beat_t       pix;
        nxt        = xorshift32(rng);
        live       = M_AXI_ARESETN && rst_prev;
        last_beat  = (beat_idx == burst_len - 1);
        req_exp    = (exp_q.size() >= burst_len);
        burst_done = 1'b0;
        // first edge after release shows the reset state
        if (M_AXI_ARESETN && !rst_prev) begin
            assert (!m_axi_awvalid && !m_axi_wvalid && !m_axi_wlast && !wr_burst_now
                    && !wr_burst_end && !wr_req)
                else count_fault("control outputs not cleared by reset");
        end
        if (live) begin
            assert (m_axi_bready) else show_mismatch("m_axi_bready", 1, m_axi_bready);
            assert (wr_req == req_exp)
                else show_mismatch("wr_req", req_exp, wr_req);
            // awvalid rises exactly one cycle after an accepted grant
            assert ((m_axi_awvalid && !aw_prev) == start_prev)
                else show_mismatch("m_axi_awvalid", start_prev, m_axi_awvalid);
            // busy from the cycle after the grant until the edge after the last beat
            assert (wr_burst_now == busy_exp)
                else show_mismatch("wr_burst_now", busy_exp, wr_burst_now);
            assert ((m_axi_wvalid && !wv_prev) == aw_hs_prev)
                else show_mismatch("m_axi_wvalid", aw_hs_prev, m_axi_wvalid);
            if (aw_stall) begin
                assert (m_axi_awvalid) else count_fault("awvalid dropped before awready");
                assert (m_axi_awaddr == awaddr_prev)
                    else show_mismatch("m_axi_awaddr", awaddr_prev, m_axi_awaddr);
            end
            if (w_stall) begin
                assert (m_axi_wvalid) else count_fault("wvalid dropped before wready");
                assert (m_axi_wdata == wdata_prev)
                    else show_mismatch("m_axi_wdata", wdata_prev, m_axi_wdata);
                assert (m_axi_wlast == wlast_prev)
                    else show_mismatch("m_axi_wlast", wlast_prev, m_axi_wlast);
            end
            if (m_axi_awvalid && m_axi_awready) begin
                // slot from the count of vsync falls
                // burst k of the frame adds k burst strides
                exp_addr = wr_base_addr + addr_t'((vs_falls % buff_num) * frame_bytes)
                           + addr_t'(burst_idx * burst_bytes);
                assert (m_axi_awaddr == exp_addr)
                    else show_mismatch("m_axi_awaddr", exp_addr, m_axi_awaddr);
                assert (m_axi_awlen == 8'(burst_len - 1))
                    else show_mismatch("m_axi_awlen", burst_len - 1, m_axi_awlen);
                assert (m_axi_awsize == size_code(beat_bytes))
                    else show_mismatch("m_axi_awsize", size_code(beat_bytes), m_axi_awsize);
                assert (m_axi_awburst == 2'b01)
                    else show_mismatch("m_axi_awburst", 1, m_axi_awburst);
                burst_idx++;
                aw_open++;
                aw_cnt <= aw_cnt + 1;
            end
            if (m_axi_wvalid && m_axi_wready) begin
                assert (aw_open > 0) else count_fault("data beat with no open address");
                if (exp_q.size() == 0) begin
                    count_fault("data beat with no pixel pending");
                end else begin
                    pix = exp_q.pop_front();
                    assert (m_axi_wdata == pix)
                        else show_mismatch("m_axi_wdata", pix, m_axi_wdata);
                end
                assert (&m_axi_wstrb)
                    else show_mismatch("m_axi_wstrb", {beat_bytes{1'b1}}, m_axi_wstrb);
                assert (m_axi_wlast == last_beat)
                    else show_mismatch("m_axi_wlast", last_beat, m_axi_wlast);
                assert (wr_burst_end == last_beat)
                    else show_mismatch("wr_burst_end", last_beat, wr_burst_end);
                if (last_beat) begin
                    beat_idx = 0;
                    aw_open--;
                    burst_done = 1'b1;
                end else begin
                    beat_idx++;
                end
            end else begin
                assert (!wr_burst_end) else count_fault("wr_burst_end without a data beat");
            end
            if (wr_burst_end) begin
                end_cnt <= end_cnt + 1;
            end
        end
        // a vsync rise flushes the fifo model
        if (pre_vs && !vs_prev) begin
            assert (exp_q.size() == 0) else count_fault("pixels left unwritten at vsync");
            exp_q.delete();
        end else if (pre_de) begin
            exp_q.push_back(beat_t'(pre_data));
        end
        if (!pre_vs && vs_prev) begin
            vs_falls++;
            burst_idx = 0;
        end
        rng <= nxt;
        if (!M_AXI_ARESETN) begin
            m_axi_awready <= 1'b0;
            m_axi_wready  <= 1'b0;
            wr_enable     <= 1'b0;
        end else begin
            // ready about three cycles in four
            m_axi_awready <= nxt[0] | nxt[1];
            m_axi_wready  <= nxt[2] | nxt[3];
            wr_enable     <= grant_en && (nxt[4] | nxt[5]);
        end
        // grant taken while idle with a full burst queued
        start_prev = M_AXI_ARESETN && req_exp && wr_enable && !busy_exp;
        if (!M_AXI_ARESETN || burst_done) begin
            busy_exp = 1'b0;
        end else if (start_prev) begin
            busy_exp = 1'b1;
        end
        aw_prev     = m_axi_awvalid;
        wv_prev     = m_axi_wvalid;
        aw_hs_prev  = m_axi_awvalid && m_axi_awready;
        aw_stall    = m_axi_awvalid && !m_axi_awready;
        w_stall     = m_axi_wvalid && !m_axi_wready;
        awaddr_prev = m_axi_awaddr;
        wdata_prev  = m_axi_wdata;
        wlast_prev  = m_axi_wlast;
        vs_prev     = pre_vs;
        rst_prev    = M_AXI_ARESETN;
    end

endmodule

//--- tb_dma_frame_writer.sv
module tb_dma_frame_writer;

    import dma_pkg::*;

    localparam addr_t base_addr        = 32'h1000_0000;
    localparam int    frames           = 4;
    localparam int    pixels           = image_w * image_h;
    localparam int    bursts_per_frame = frame_bytes / burst_bytes;
    localparam int    wait_limit       = 5000;

    logic                  M_AXI_ACLK = 1'b0;
    logic                  M_AXI_ARESETN;
    addr_t                 m_axi_awaddr;
    logic [7:0]            m_axi_awlen;
    logic [2:0]            m_axi_awsize;
    logic [1:0]            m_axi_awburst;
    logic                  m_axi_awvalid;
    logic                  m_axi_awready;
    beat_t                 m_axi_wdata;
    logic [beat_bytes-1:0] m_axi_wstrb;
    logic                  m_axi_wlast;
    logic                  m_axi_wvalid;
    logic                  m_axi_wready;
    logic [1:0]            m_axi_bresp;
    logic                  m_axi_bvalid;
    logic                  m_axi_bready;
    logic                  pre_vs;
    logic                  pre_de;
    logic [pixel_w-1:0]    pre_data;
    logic                  wr_req;
    logic                  wr_enable;
    logic                  wr_burst_now;
    logic                  wr_burst_end;
    logic                  grant_en;
    logic [31:0]           rnd;
    int                    aw_cnt;
    int                    end_cnt;
    int                    mismatch_cnt;
    int                    fault_cnt;
    int                    tb_faults = 0;
    logic                  timed_out = 1'b0;

    dma_frame_writer #(.wr_base_addr(base_addr)) dut0 (.*);

    // axi slave, grant source and all bus checks
    tb_axi_slave #(.wr_base_addr(base_addr)) slave0 (.*);

    always #50 M_AXI_ACLK = ~M_AXI_ACLK;

    task automatic note_failure(input string what);
        $display("error at %0t: %s", $time, what);
        tb_faults++;
    endtask

    task automatic pulse_vsync();
        @(posedge M_AXI_ACLK);
        pre_vs <= 1'b1;
        repeat (3) @(posedge M_AXI_ACLK);
        pre_vs <= 1'b0;
        // let the new base reach the address counter
        repeat (3) @(posedge M_AXI_ACLK);
    endtask

    // one frame of pixels, random gaps in data enable
    task automatic send_frame();
        int sent;
        int cycles;
        sent   = 0;
        cycles = 0;
        while (sent < pixels && cycles < wait_limit) begin
            @(posedge M_AXI_ACLK);
            cycles++;
            if (rnd[31:30] != 2'b00) begin
                pre_de   <= 1'b1;
                pre_data <= rnd[pixel_w-1:0];
                sent++;
            end else begin
                pre_de <= 1'b0;
            end
        end
        @(posedge M_AXI_ACLK);
        pre_de <= 1'b0;
        if (sent < pixels) begin
            note_failure("timeout while sending pixels");
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_bursts(input int target);
        int cycles;
        cycles = 0;
        while ((end_cnt < target || wr_burst_now) && cycles < wait_limit) begin
            @(posedge M_AXI_ACLK);
            cycles++;
        end
        if (cycles >= wait_limit) begin
            note_failure($sformatf("timeout waiting for %0d finished bursts", target));
            timed_out = 1'b1;
        end
    endtask

    task automatic finish_run();
        int other;
        other = fault_cnt + tb_faults;
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other);
        if (mismatch_cnt == 0 && other == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        M_AXI_ARESETN = 1'b0;
        pre_vs        = 1'b0;
        pre_de        = 1'b0;
        pre_data      = '0;
        m_axi_bresp   = 2'b00;
        m_axi_bvalid  = 1'b0;
        grant_en      = 1'b0;
        repeat (4) @(posedge M_AXI_ACLK);
        M_AXI_ARESETN <= 1'b1;
        for (int f = 1; f <= frames && !timed_out; f++) begin
            pulse_vsync();
            send_frame();
            if (f == 1) begin
                // whole frame queued, no grant yet
                @(posedge M_AXI_ACLK);
                assert (wr_req && !m_axi_awvalid && !wr_burst_now)
                    else note_failure("burst started without a grant");
                grant_en <= 1'b1;
            end
            wait_bursts(f * bursts_per_frame);
            if (!timed_out) begin
                assert (aw_cnt == f * bursts_per_frame && end_cnt == aw_cnt)
                    else note_failure($sformatf("frame %0d: %0d addresses, %0d burst ends",
                                                f, aw_cnt, end_cnt));
            end
        end
        finish_run();
    end

endmodule

//--- wdata_beat.sv
module wdata_beat (
    input  logic M_AXI_ACLK,
    input  logic M_AXI_ARESETN,
    input  logic awvalid,
    input  logic awready,
    input  logic wready,
    output logic wvalid,
    output logic wlast,
    output logic pop,
    output logic burst_end
);

    import dma_pkg::*;

    beat_cnt_t beat_cnt;
    logic      aw_hs;
    logic      w_hs;
    logic      on_last;

    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;
    assign on_last = (beat_cnt == beat_cnt_t'(burst_len - 1));

    // last flag tracks the counter, no extra state
    assign wlast = wvalid && on_last;

    // every accepted beat takes one word off the fifo
    assign pop = w_hs;

    // strobe on the final handshake
    assign burst_end = w_hs && on_last;

    // data phase opens after the address is taken
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            wvalid <= 1'b0;
        end else if (burst_end) begin
            wvalid <= 1'b0;
        end else if (aw_hs) begin
            wvalid <= 1'b1;
        end
    end

    // beat index within the burst
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            beat_cnt <= '0;
        end else if (burst_end) begin
            beat_cnt <= '0;
        end else if (w_hs) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

endmodule
